// ==== design/fetch_config.svh ====
// Fetch stage build macros for prefetch depth, boot PC and executable region
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// Prefetch FIFO depth
// Also caps the reads in flight, keep it at 2 or more
`define PF_DEPTH 2

// PC held through reset until the controller issues the first redirect
`define BOOT_RESET_PC 32'h0000_0080

// Executable window for instruction fetch
// Base is inclusive, limit is exclusive, both byte addresses of words
`define EXEC_BASE  32'h0000_0000
`define EXEC_LIMIT 32'h0001_0000

`endif

// ==== design/fetch_pkg.sv ====
// Fetch stage types: PC source enum, controller struct, AXI read structs, IF/ID structs
package fetch_pkg;

  // Redirect target select, driven by the controller with pc_set
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,  // Boot address
    PC_JUMP     = 3'd1,  // Jump from ID
    PC_BRANCH   = 3'd2,  // Taken branch from EX
    PC_MRET     = 3'd3,  // Return from trap
    PC_TRAP_EXC = 3'd4,  // Exception entry, mtvec base
    PC_TRAP_IRQ = 3'd5   // Vectored interrupt entry
  } pc_mux_e;

  // Prefetcher run state
  typedef enum logic {
    PF_IDLE = 1'b0,  // Out of reset, nothing requested yet
    PF_RUN  = 1'b1   // Fetching after the first redirect
  } pf_state_e;

  // Controller to IF stage
  typedef struct packed {
    logic       pc_set;   // Single cycle redirect strobe
    pc_mux_e    pc_mux;
    logic [4:0] irq_id;   // Interrupt vector index
    logic       kill_if;
    logic       halt_if;
    logic       spare;
  } ctrl_fetch_t;

  // AXI4-Lite AR payload
  typedef struct packed {
    logic [31:0] addr;
    logic [2:0]  prot;
  } axi_ar_t;

  // AXI4-Lite R payload
  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } axi_r_t;

  // One fetched word plus its fault flags
  typedef struct packed {
    logic [31:0] instr;
    logic        bus_err;  // Slave answered with SLVERR or DECERR
    logic        pma_err;  // Outside executable region, never sent to the bus
  } fetch_resp_t;

  // IF/ID pipeline register
  typedef struct packed {
    logic        instr_valid;
    logic [31:0] pc;
    fetch_resp_t resp;
  } if_id_pipe_t;

  // AXI prot for fetch: unprivileged, secure, instruction
  localparam logic [2:0] PROT_INSTR    = 3'b100;
  localparam logic [1:0] AXI_RESP_OKAY = 2'b00;

endpackage

// ==== design/fetch_axi_rd.sv ====
// AXI4-Lite read master for instruction fetch with one registered AR slot
`timescale 1ns/1ps

module fetch_axi_rd (
  input  logic                   clk,
  input  logic                   rst_n,

  // Request from the PMA stage
  input  logic                   trans_valid_i,
  output logic                   trans_ready_o,
  input  logic [31:0]            trans_addr_i,

  // Response back towards the prefetcher
  output logic                   resp_valid_o,
  output fetch_pkg::fetch_resp_t resp_o,

  // AR channel
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output fetch_pkg::axi_ar_t     ar_o,

  // R channel
  input  logic                   r_valid_i,
  output logic                   r_ready_o,
  input  fetch_pkg::axi_r_t      r_i
);
  import fetch_pkg::*;

  logic        ar_valid_q;  // Address waiting for the slave
  logic [31:0] ar_addr_q;
  logic        trans_hs;

  // Only one address held, take a new one once the slot is empty
  assign trans_ready_o = !ar_valid_q;
  assign trans_hs      = trans_valid_i && trans_ready_o;

  // AR valid rises the cycle after the internal handshake
  // and stays up until the slave takes it
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      ar_valid_q <= 1'b0;
    end else if (trans_hs) begin
      ar_valid_q <= 1'b1;
    end else if (ar_ready_i) begin
      ar_valid_q <= 1'b0;                      // Accepted by the slave
    end
  end

  // Address only loads into an empty slot, so it is stable while stalled
  always_ff @(posedge clk) begin
    if (trans_hs) begin
      ar_addr_q <= trans_addr_i;
    end
  end

  assign ar_valid_o = ar_valid_q;
  assign ar_o       = '{addr: ar_addr_q, prot: PROT_INSTR};

  // R channel is never back-pressured, prefetcher reserves a FIFO slot per read
  assign r_ready_o    = 1'b1;
  assign resp_valid_o = r_valid_i;             // Same cycle pass to the core side

  always_comb begin
    resp_o.instr   = r_i.data;
    resp_o.bus_err = (r_i.resp != AXI_RESP_OKAY);  // SLVERR / DECERR
    resp_o.pma_err = 1'b0;
  end

endmodule

// ==== design/fetch_pma.sv ====
// Executable region check between prefetcher and AXI read master
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_pma (
  input  logic                   clk,
  input  logic                   rst_n,

  // Core side
  input  logic                   core_valid_i,
  output logic                   core_ready_o,
  input  logic [31:0]            core_addr_i,
  output logic                   core_resp_valid_o,
  output fetch_pkg::fetch_resp_t core_resp_o,

  // Bus side
  output logic                   bus_valid_o,
  input  logic                   bus_ready_i,
  output logic [31:0]            bus_addr_o,
  input  logic                   bus_resp_valid_i,
  input  fetch_pkg::fetch_resp_t bus_resp_i
);
  import fetch_pkg::*;

  localparam int unsigned CNT_W = 4;  // Room for far more reads than the prefetcher issues

  logic             exec_ok;    // Address inside the executable window
  logic             bus_hs;
  logic             fault_hs;   // Illegal request taken this cycle
  logic             fault_q;    // Fault answer due this cycle
  logic [CNT_W-1:0] bus_cnt_q;  // Bus reads still in flight

  assign exec_ok = (core_addr_i >= `EXEC_BASE) && (core_addr_i < `EXEC_LIMIT);

  // Legal requests go straight through
  assign bus_valid_o = core_valid_i && exec_ok;
  assign bus_addr_o  = core_addr_i;
  assign bus_hs      = bus_valid_o && bus_ready_i;

  // Illegal ones wait until the bus has drained so answers stay in order
  assign core_ready_o = exec_ok ? bus_ready_i : (bus_cnt_q == '0);
  assign fault_hs     = core_valid_i && !exec_ok && (bus_cnt_q == '0);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      bus_cnt_q <= '0;
      fault_q   <= 1'b0;
    end else begin
      fault_q <= fault_hs;                     // Answer one cycle after acceptance
      case ({bus_hs, bus_resp_valid_i})
        2'b10:   bus_cnt_q <= bus_cnt_q + 1'b1;
        2'b01:   bus_cnt_q <= bus_cnt_q - 1'b1;
        default: ;                             // Both or neither
      endcase
    end
  end

  // A fault answer never meets a bus answer, the bus was empty when it was taken
  assign core_resp_valid_o = fault_q || bus_resp_valid_i;

  always_comb begin
    core_resp_o = bus_resp_i;
    if (fault_q) begin
      core_resp_o = '{instr: 32'h0, bus_err: 1'b0, pma_err: 1'b1};
    end
  end

endmodule

// ==== design/fetch_prefetch.sv ====
// Prefetcher with request address counter, read tracking, response FIFO and redirect flush
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_prefetch (
  input  logic                   clk,
  input  logic                   rst_n,

  input  fetch_pkg::ctrl_fetch_t ctrl_i,
  input  logic [31:0]            branch_addr_i,   // Redirect target, word aligned

  // Towards the IF/ID register
  input  logic                   ready_i,
  output logic                   valid_o,
  output fetch_pkg::fetch_resp_t instr_o,
  output logic [31:0]            addr_o,          // PC of the FIFO head

  // Request and response path
  output logic                   trans_valid_o,
  input  logic                   trans_ready_i,
  output logic [31:0]            trans_addr_o,
  input  logic                   resp_valid_i,
  input  fetch_pkg::fetch_resp_t resp_i,

  output logic                   busy_o
);
  import fetch_pkg::*;

  localparam int unsigned      DEPTH    = `PF_DEPTH;
  localparam int unsigned      PTR_W    = $clog2(DEPTH);
  localparam int unsigned      CNT_W    = $clog2(DEPTH + 1);
  localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(DEPTH - 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

  pf_state_e        state_q;
  logic [31:0]      fetch_addr_q;   // Next word to request
  logic [31:0]      head_pc_q;
  fetch_resp_t      fifo_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] fifo_cnt_q;
  logic [CNT_W-1:0] outst_cnt_q;    // Reads issued, not yet answered
  logic [CNT_W-1:0] discard_cnt_q;  // Stale answers still to drop
  logic [CNT_W:0]   occupancy;      // FIFO entries plus reads in flight
  logic             trans_hs;
  logic             push;
  logic             pop;
  logic             drop;

  // Ring pointer step, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_LAST) ? '0 : ptr + 1'b1;
  endfunction

  //////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////

  assign occupancy = {1'b0, fifo_cnt_q} + {1'b0, outst_cnt_q};

  // Hold off on the redirect cycle, new target goes out next cycle
  assign trans_valid_o = (state_q == PF_RUN) && !ctrl_i.pc_set
                         && (occupancy < {1'b0, CNT_FULL});
  assign trans_hs      = trans_valid_o && trans_ready_i;
  assign trans_addr_o  = fetch_addr_q;

  //////////////////////////////////////////////////
  // Response side
  //////////////////////////////////////////////////

  // Anything landing on a redirect or owed to an old stream is thrown away
  assign drop = resp_valid_i && ((discard_cnt_q != '0) || ctrl_i.pc_set);
  assign push = resp_valid_i && !drop;

  assign valid_o = (fifo_cnt_q != '0);
  assign pop     = valid_o && ready_i && !ctrl_i.pc_set;
  assign instr_o = fifo_q[rd_ptr_q];
  assign addr_o  = head_pc_q;
  assign busy_o  = (outst_cnt_q != '0);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      state_q       <= PF_IDLE;
      fetch_addr_q  <= `BOOT_RESET_PC;
      head_pc_q     <= `BOOT_RESET_PC;
      wr_ptr_q      <= '0;
      rd_ptr_q      <= '0;
      fifo_cnt_q    <= '0;
      outst_cnt_q   <= '0;
      discard_cnt_q <= '0;
    end else begin
      case ({trans_hs, resp_valid_i})          // Issue and return, one each per cycle at most
        2'b10:   outst_cnt_q <= outst_cnt_q + 1'b1;
        2'b01:   outst_cnt_q <= outst_cnt_q - 1'b1;
        default: ;
      endcase
      if (ctrl_i.pc_set) begin
        // Redirect flushes the FIFO and marks every open read as stale
        state_q       <= PF_RUN;
        fetch_addr_q  <= branch_addr_i;
        head_pc_q     <= branch_addr_i;
        wr_ptr_q      <= '0;
        rd_ptr_q      <= '0;
        fifo_cnt_q    <= '0;
        discard_cnt_q <= outst_cnt_q - CNT_W'(resp_valid_i);
      end else begin
        if (trans_hs) fetch_addr_q <= fetch_addr_q + 32'd4;
        if (push) wr_ptr_q <= ptr_inc(wr_ptr_q);
        if (pop) begin
          rd_ptr_q  <= ptr_inc(rd_ptr_q);
          head_pc_q <= head_pc_q + 32'd4;      // Stream is strictly sequential
        end
        case ({push, pop})
          2'b10:   fifo_cnt_q <= fifo_cnt_q + 1'b1;
          2'b01:   fifo_cnt_q <= fifo_cnt_q - 1'b1;
          default: ;
        endcase
        if (drop) discard_cnt_q <= discard_cnt_q - 1'b1;
      end
    end
  end

  // FIFO storage
  always_ff @(posedge clk) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= resp_i;
    end
  end

endmodule

// ==== design/fetch_if_stage.sv ====
// Instruction fetch stage top with target select, stage handshake and IF/ID register
`timescale 1ns/1ps

module fetch_if_stage (
  input  logic                   clk,
  input  logic                   rst_n,

  // Redirect targets
  input  logic [31:0]            boot_addr_i,
  input  logic [31:0]            jump_target_i,
  input  logic [31:0]            branch_target_i,
  input  logic [31:0]            mepc_i,
  input  logic [23:0]            mtvec_addr_i,    // Trap vector base, upper bits

  input  fetch_pkg::ctrl_fetch_t ctrl_i,

  // AXI4-Lite read
  output logic                   ar_valid_o,
  input  logic                   ar_ready_i,
  output fetch_pkg::axi_ar_t     ar_o,
  input  logic                   r_valid_i,
  output logic                   r_ready_o,
  input  fetch_pkg::axi_r_t      r_i,

  // ID side
  output fetch_pkg::if_id_pipe_t if_id_pipe_o,
  output logic                   if_valid_o,
  input  logic                   id_ready_i,
  output logic                   csr_mtvec_init_o,  // mtvec reload on boot
  output logic                   if_busy_o
);
  import fetch_pkg::*;

  logic [31:0] branch_addr_n;
  logic        if_ready;

  logic        pf_valid;
  fetch_resp_t pf_instr;
  logic [31:0] pf_pc;
  logic        pf_busy;
  logic        pf_trans_valid;
  logic        pf_trans_ready;
  logic [31:0] pf_trans_addr;
  logic        pf_resp_valid;
  fetch_resp_t pf_resp;

  logic        bus_trans_valid;
  logic        bus_trans_ready;
  logic [31:0] bus_trans_addr;
  logic        bus_resp_valid;
  fetch_resp_t bus_resp;

  logic        instr_valid_q;
  logic [31:0] pc_q;
  fetch_resp_t resp_q;

  //////////////////////////////////////////////////
  // Redirect target
  //////////////////////////////////////////////////

  always_comb begin
    branch_addr_n = {boot_addr_i[31:2], 2'b00};  // Fallback for unused codes
    case (ctrl_i.pc_mux)
      PC_BOOT:     branch_addr_n = {boot_addr_i[31:2], 2'b00};
      PC_JUMP:     branch_addr_n = {jump_target_i[31:2], 2'b00};
      PC_BRANCH:   branch_addr_n = {branch_target_i[31:2], 2'b00};
      PC_MRET:     branch_addr_n = {mepc_i[31:2], 2'b00};
      PC_TRAP_EXC: branch_addr_n = {mtvec_addr_i, 8'h00};             // Common exception entry
      PC_TRAP_IRQ: branch_addr_n = {mtvec_addr_i, 1'b0, ctrl_i.irq_id, 2'b00};  // Vectored
      default:     ;
    endcase
  end

  assign csr_mtvec_init_o = ctrl_i.pc_set && (ctrl_i.pc_mux == PC_BOOT);

  //////////////////////////////////////////////////
  // Fetch path
  //////////////////////////////////////////////////

  fetch_prefetch prefetch_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .ctrl_i        (ctrl_i),
    .branch_addr_i (branch_addr_n),
    .ready_i       (if_ready),
    .valid_o       (pf_valid),
    .instr_o       (pf_instr),
    .addr_o        (pf_pc),
    .trans_valid_o (pf_trans_valid),
    .trans_ready_i (pf_trans_ready),
    .trans_addr_o  (pf_trans_addr),
    .resp_valid_i  (pf_resp_valid),
    .resp_i        (pf_resp),
    .busy_o        (pf_busy)
  );

  fetch_pma pma_i (
    .clk               (clk),
    .rst_n             (rst_n),
    .core_valid_i      (pf_trans_valid),
    .core_ready_o      (pf_trans_ready),
    .core_addr_i       (pf_trans_addr),
    .core_resp_valid_o (pf_resp_valid),
    .core_resp_o       (pf_resp),
    .bus_valid_o       (bus_trans_valid),
    .bus_ready_i       (bus_trans_ready),
    .bus_addr_o        (bus_trans_addr),
    .bus_resp_valid_i  (bus_resp_valid),
    .bus_resp_i        (bus_resp)
  );

  fetch_axi_rd axi_rd_i (
    .clk           (clk),
    .rst_n         (rst_n),
    .trans_valid_i (bus_trans_valid),
    .trans_ready_o (bus_trans_ready),
    .trans_addr_i  (bus_trans_addr),
    .resp_valid_o  (bus_resp_valid),
    .resp_o        (bus_resp),
    .ar_valid_o    (ar_valid_o),
    .ar_ready_i    (ar_ready_i),
    .ar_o          (ar_o),
    .r_valid_i     (r_valid_i),
    .r_ready_o     (r_ready_o),
    .r_i           (r_i)
  );

  //////////////////////////////////////////////////
  // Stage handshake and IF/ID register
  //////////////////////////////////////////////////

  assign if_valid_o = pf_valid && !ctrl_i.kill_if && !ctrl_i.halt_if;
  assign if_ready   = ctrl_i.kill_if || (id_ready_i && !ctrl_i.halt_if);  // Kill drains the head
  assign if_busy_o  = pf_busy;

  // Bubble when ID takes but IF has nothing, hold when ID stalls
  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      instr_valid_q <= 1'b0;
    end else if (if_valid_o && id_ready_i) begin
      instr_valid_q <= 1'b1;
    end else if (id_ready_i) begin
      instr_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (if_valid_o && id_ready_i) begin
      pc_q   <= pf_pc;
      resp_q <= pf_instr;
    end
  end

  assign if_id_pipe_o = '{instr_valid: instr_valid_q, pc: pc_q, resp: resp_q};

endmodule

// ==== tests/fetch_assert.sv ====
// AXI read and stage handshake assertions for the fetch stage, bound into the top level
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_assert (
  input logic                   clk,
  input logic                   rst_n,
  input fetch_pkg::ctrl_fetch_t ctrl_i,
  input logic                   ar_valid_i,
  input logic                   ar_ready_i,
  input fetch_pkg::axi_ar_t     ar_i,
  input logic                   r_valid_i,
  input logic                   if_valid_i
);

  logic        started_q;     // First redirect seen
  logic [3:0]  inflight_q;    // AR taken, R not back yet
  int unsigned fail_cnt = 0;  // Failed assertions so far

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      started_q  <= 1'b0;
      inflight_q <= '0;
    end else begin
      if (ctrl_i.pc_set) started_q <= 1'b1;
      inflight_q <= inflight_q + 4'(ar_valid_i && ar_ready_i) - 4'(r_valid_i);
    end
  end

  ar_stable: assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
    else begin
      $error("AR dropped or changed while waiting for ready");
      fail_cnt++;
    end

  no_early_ar: assert property (@(posedge clk) disable iff (!rst_n)
    !started_q |-> !ar_valid_i)
    else begin
      $error("AR valid before the first redirect");
      fail_cnt++;
    end

  kill_blocks_valid: assert property (@(posedge clk) disable iff (!rst_n)
    ctrl_i.kill_if |-> !if_valid_i)
    else begin
      $error("IF valid while kill_if is set");
      fail_cnt++;
    end

  // Bus reads in flight never exceed the prefetch depth
  inflight_cap: assert property (@(posedge clk) disable iff (!rst_n)
    inflight_q <= `PF_DEPTH)
    else begin
      $error("Too many reads in flight");
      fail_cnt++;
    end

endmodule

bind fetch_if_stage fetch_assert fetch_assert_i (
  .clk        (clk),
  .rst_n      (rst_n),
  .ctrl_i     (ctrl_i),
  .ar_valid_i (ar_valid_o),
  .ar_ready_i (ar_ready_i),
  .ar_i       (ar_o),
  .r_valid_i  (r_valid_i),
  .if_valid_i (if_valid_o)
);

// ==== tests/fetch_tb.sv ====
// Fetch stage testbench with clock, reset, AXI memory model, directed tests and watchdog
`timescale 1ns/1ps
`include "fetch_config.svh"

module fetch_tb;
  import fetch_pkg::*;

  localparam int          NUM_TESTS       = 6;
  localparam int          CYCLES_PER_TEST = 200;
  localparam logic [31:0] DATA_KEY        = 32'h5a5a_0000;  // Memory word = address ^ key
  localparam logic [31:0] ERR_BASE        = 32'h0000_4000;  // SLVERR window, inclusive
  localparam logic [31:0] ERR_LIMIT       = 32'h0000_4010;  // Exclusive
  localparam logic [2:0]  PROT_FETCH      = 3'b100;         // Unprivileged, secure, instruction

  logic        clk;
  logic        rst_n;
  logic [31:0] boot_addr;
  logic [31:0] jump_target;
  logic [31:0] branch_target;
  logic [31:0] mepc;
  logic [23:0] mtvec_addr;
  ctrl_fetch_t ctrl;
  logic        ar_valid;
  logic        ar_ready;
  axi_ar_t     ar;
  logic        r_valid;
  logic        r_ready;
  axi_r_t      r;
  if_id_pipe_t if_id_pipe;
  logic        if_valid;
  logic        id_ready;
  logic        csr_mtvec_init;
  logic        if_busy;

  integer      seed       = 32'hdf66;  // Memory model delays
  integer      stall_seed = 32'hdf66;  // Stall lengths in the tests
  logic [31:0] addr_q [$];             // Reads accepted, answered in order
  logic [31:0] ar_log [$];             // Every address seen on AR
  int          ar_dly;
  int          r_dly;
  bit          ar_taken;
  bit          r_taken;
  logic [31:0] next_pc;                // Next pc expected in the stream
  int          err_cnt;

  fetch_if_stage fetch_if_stage_i (
    .clk              (clk),
    .rst_n            (rst_n),
    .boot_addr_i      (boot_addr),
    .jump_target_i    (jump_target),
    .branch_target_i  (branch_target),
    .mepc_i           (mepc),
    .mtvec_addr_i     (mtvec_addr),
    .ctrl_i           (ctrl),
    .ar_valid_o       (ar_valid),
    .ar_ready_i       (ar_ready),
    .ar_o             (ar),
    .r_valid_i        (r_valid),
    .r_ready_o        (r_ready),
    .r_i              (r),
    .if_id_pipe_o     (if_id_pipe),
    .if_valid_o       (if_valid),
    .id_ready_i       (id_ready),
    .csr_mtvec_init_o (csr_mtvec_init),
    .if_busy_o        (if_busy)
  );

  always #2 clk = ~clk;

  //////////////////////////////////////////////////
  // AXI memory model
  //////////////////////////////////////////////////

  // Handshakes are seen on the rising edge, DUT flops update after this block reads them
  always @(posedge clk) begin
    if (ar_valid && ar_ready) begin
      assert (ar.prot === PROT_FETCH) else report_mismatch("ar prot", PROT_FETCH, ar.prot);
      addr_q.push_back(ar.addr);
      ar_log.push_back(ar.addr);
      ar_taken = 1'b1;
    end
    if (r_valid) begin
      assert (r_ready === 1'b1) else report_error("r_ready low while a read response is valid");
    end
    if (r_valid && r_ready) begin
      void'(addr_q.pop_front());
      r_taken = 1'b1;
    end
  end

  // New ready and response values go out on the falling edge
  always @(negedge clk) begin
    if (ar_taken) begin
      ar_dly   = $unsigned($random(seed)) % 4;
      ar_taken = 1'b0;
    end
    if (ar_dly == 0) ar_ready = 1'b1;
    else begin
      ar_ready = 1'b0;
      ar_dly--;
    end
    if (r_taken) begin
      r_valid = 1'b0;
      r_taken = 1'b0;
      r_dly   = $unsigned($random(seed)) % 4;
    end
    if (!r_valid && addr_q.size() != 0) begin
      if (r_dly == 0) begin
        r_valid = 1'b1;
        r.data  = addr_q[0] ^ DATA_KEY;
        r.resp  = (addr_q[0] >= ERR_BASE && addr_q[0] < ERR_LIMIT) ? 2'b10 : 2'b00;
      end else r_dly--;
    end
  end

  // Busy while the memory still owes an answer, protocol checker clean
  always @(negedge clk) begin
    if (fetch_if_stage_i.fetch_assert_i.fail_cnt != 0) begin
      report_error("a bound protocol assertion failed");
    end
    if (addr_q.size() != 0) begin
      assert (if_busy === 1'b1) else report_error("if_busy low while a read is in flight");
    end
  end

  //////////////////////////////////////////////////
  // Checking helpers
  //////////////////////////////////////////////////

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    err_cnt++;
    $display("Fail %s: expected %h, actual %h", name, exp_val, act_val);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic report_error(input string what);
    err_cnt++;
    $display("Error: %s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] act_val);
    assert (act_val === exp_val) else report_mismatch(name, exp_val, act_val);
  endtask

  // Response expected for a pc from the region and error window rules
  function automatic fetch_resp_t expect_resp(input logic [31:0] pc);
    fetch_resp_t exp_r;
    exp_r.pma_err = !(pc >= `EXEC_BASE && pc < `EXEC_LIMIT);
    exp_r.bus_err = !exp_r.pma_err && (pc >= ERR_BASE) && (pc < ERR_LIMIT);
    exp_r.instr   = exp_r.pma_err ? 32'h0 : (pc ^ DATA_KEY);
    return exp_r;
  endfunction

  // Returns on the falling edge after IF/ID took a new entry
  task automatic wait_entry();
    do @(negedge clk); while (!(if_id_pipe.instr_valid && id_ready));
  endtask

  task automatic check_stream(input string name, input logic [31:0] start, input int n);
    logic [31:0] pc;
    fetch_resp_t exp_r;
    int          i;
    for (i = 0; i < n; i++) begin
      pc    = start + 32'(4 * i);
      exp_r = expect_resp(pc);
      wait_entry();
      check_value({name, " pc"}, pc, if_id_pipe.pc);
      check_value({name, " instr"}, exp_r.instr, if_id_pipe.resp.instr);
      check_value({name, " bus_err"}, exp_r.bus_err, if_id_pipe.resp.bus_err);
      check_value({name, " pma_err"}, exp_r.pma_err, if_id_pipe.resp.pma_err);
    end
    next_pc = start + 32'(4 * n);
  endtask

  // Controller style redirect, kill_if drops the old head on the same cycle
  task automatic redirect(input pc_mux_e mux, input logic [4:0] irq);
    ctrl.pc_set  = 1'b1;
    ctrl.kill_if = 1'b1;
    ctrl.pc_mux  = mux;
    ctrl.irq_id  = irq;
    #1;
    check_value("mtvec_init", mux == PC_BOOT, csr_mtvec_init);
    @(negedge clk);
    ctrl.pc_set  = 1'b0;
    ctrl.kill_if = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_boot();
    repeat (3) @(negedge clk);                 // Idle, nothing may start yet
    check_value("idle ar_valid", 0, ar_valid);
    check_value("idle if_valid", 0, if_valid);
    check_value("idle instr_valid", 0, if_id_pipe.instr_valid);
    check_value("idle mtvec_init", 0, csr_mtvec_init);
    check_value("idle busy", 0, if_busy);
    redirect(PC_BOOT, 5'd0);
    check_stream("boot", 32'h0000_0100, 8);
  endtask

  task automatic test_redirects();
    redirect(PC_JUMP, 5'd0);
    check_stream("jump", 32'h0000_0500, 4);
    redirect(PC_BRANCH, 5'd0);
    check_stream("branch", 32'h0000_0a04, 4);
    redirect(PC_MRET, 5'd0);
    check_stream("mret", 32'h0000_2000, 4);
  endtask

  task automatic test_traps();
    logic [4:0] irq_list [3];
    int         i;
    irq_list = '{5'd3, 5'd17, 5'd31};
    redirect(PC_TRAP_EXC, 5'd9);               // irq_id must not matter here
    check_stream("trap_exc", 32'h0000_1200, 2);
    for (i = 0; i < 3; i++) begin
      redirect(PC_TRAP_IRQ, irq_list[i]);
      check_stream("trap_irq", 32'h0000_1200 | (32'(irq_list[i]) << 2), 2);
    end
  endtask

  task automatic test_bus_error();
    branch_target = 32'h0000_3ffa;
    redirect(PC_BRANCH, 5'd0);
    check_stream("bus_err", 32'h0000_3ff8, 6);  // Two clean words, then four errors
  endtask

  task automatic test_stall_halt();
    if_id_pipe_t held;
    int          len;
    logic [31:0] resume_pc;
    resume_pc = next_pc;
    len       = 4 + ($unsigned($random(stall_seed)) % 12);
    id_ready  = 1'b0;
    held      = if_id_pipe;
    repeat (len) begin
      @(negedge clk);
      check_value("stall pc", held.pc, if_id_pipe.pc);
      check_value("stall instr", held.resp.instr, if_id_pipe.resp.instr);
      check_value("stall flags", {held.resp.bus_err, held.resp.pma_err},
                  {if_id_pipe.resp.bus_err, if_id_pipe.resp.pma_err});
      check_value("stall valid", held.instr_valid, if_id_pipe.instr_valid);
    end
    id_ready     = 1'b1;
    ctrl.halt_if = 1'b1;
    repeat (len) begin
      @(negedge clk);
      check_value("halt if_valid", 0, if_valid);
    end
    ctrl.halt_if = 1'b0;
    check_stream("stall_resume", resume_pc, 4);
  endtask

  task automatic test_pma_fault();
    int i;
    jump_target = `EXEC_LIMIT - 32'd8;
    redirect(PC_JUMP, 5'd0);
    check_stream("pma", `EXEC_LIMIT - 32'd8, 3);
    for (i = 0; i < ar_log.size(); i++) begin
      assert (ar_log[i] < `EXEC_LIMIT)
        else report_error("an address outside the executable region reached the AR channel");
    end
  endtask

  //////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////

  initial begin
    clk           = 1'b0;
    rst_n         = 1'b0;
    boot_addr     = 32'h0000_0102;             // Low bits must be cleared by the DUT
    jump_target   = 32'h0000_0503;
    branch_target = 32'h0000_0a06;
    mepc          = 32'h0000_2001;
    mtvec_addr    = 24'h00_0012;
    ctrl          = '0;
    ar_ready      = 1'b0;
    r_valid       = 1'b0;
    r             = '0;
    id_ready      = 1'b1;
    err_cnt       = 0;
    next_pc       = 32'h0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    test_boot();
    test_redirects();
    test_traps();
    test_bus_error();
    test_stall_halt();
    test_pma_fault();
    repeat (4) @(negedge clk);
    if (err_cnt == 0 && fetch_if_stage_i.fetch_assert_i.fail_cnt == 0) begin
      $display("All checks passed");
      $finish;
    end else begin
      $display("Checks failed");
      $fatal(1);
    end
  end

  initial begin
    repeat (CYCLES_PER_TEST * NUM_TESTS) @(posedge clk);
    $display("Timeout: fetch made no progress");
    $display("Checks failed");
    $fatal(1);
  end

endmodule

// ==== build.f ====
+incdir+design
design/fetch_pkg.sv
design/fetch_axi_rd.sv
design/fetch_pma.sv
design/fetch_prefetch.sv
design/fetch_if_stage.sv
tests/fetch_assert.sv
tests/fetch_tb.sv

// ==== Bender.yml ====
package:
  name: fetch_stage

sources:
  - include_dirs:
      - design
    files:
      - design/fetch_pkg.sv
      - design/fetch_axi_rd.sv
      - design/fetch_pma.sv
      - design/fetch_prefetch.sv
      - design/fetch_if_stage.sv
  - target: test
    include_dirs:
      - design
    files:
      - tests/fetch_assert.sv
      - tests/fetch_tb.sv
